/* fm_mmr.f */
verilog/fm_mmr_pkg.sv
verilog/fm_bus_capture.sv
verilog/fm_global_regs.sv
verilog/fm_update_decode.sv
verilog/fm_prescaler.sv
verilog/fm_busy_timer.sv
verilog/fm_mmr.sv
verification/fm_mmr_tb.sv

/* Makefile */
# Verilator build and run for fm_mmr

VERILATOR ?= verilator
TOP       ?= fm_mmr_tb
FILELIST  ?= fm_mmr.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/fm_mmr_tb.sv */
`timescale 1ns/1ps

module fm_mmr_tb;

    import fm_mmr_pkg::*;

    localparam int MAX_CYCLES = 20000; // About 200 writes with busy waits, plus margin

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic       write;
    logic [1:0] addr;
    logic       clk_en;
    logic       busy;
    fm_timer_t  timer;
    fm_lfo_t    lfo;
    fm_pcm_t    pcm;
    fm_test_t   test;
    fm_update_t update;

    fm_timer_t  exp_timer;
    fm_lfo_t    exp_lfo;
    fm_pcm_t    exp_pcm;
    fm_test_t   exp_test;
    fm_update_t exp_update;
    int         cyc;
    int         due_cyc;
    int         errors;
    int         checks;
    logic       cen_toggle;
    logic [31:0] lfsr;

    fm_mmr #(.USE_PCM(1)) u_fm_mmr (
        .clk(clk), .rst(rst), .cen(cen), .din(din), .write(write), .addr(addr),
        .clk_en(clk_en), .busy(busy), .timer(timer), .lfo(lfo), .pcm(pcm),
        .test(test), .update(update)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle counter and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Random on-off cen pattern in the toggle phase
    always @(posedge clk) cen <= cen_toggle ? take_bits(1) != 0 : 1'b1;

    // Expected register state after one data write
    task automatic apply_model(input logic part, input logic [7:0] num, input logic [7:0] d);
        logic [3:0] hi;
        hi = num[7:4];
        if (!part) begin
            case (num)
                REG_TEST: begin
                    exp_test.eg_stop = d[5];
                    exp_test.pg_stop = d[3];
                    exp_timer.fast   = d[2];
                end
                REG_LFO: begin
                    exp_lfo.en   = d[3];
                    exp_lfo.freq = d[2:0];
                end
                REG_CLKA1: exp_timer.value_a[9:2] = d;
                REG_CLKA2: exp_timer.value_a[1:0] = d[1:0];
                REG_CLKB:  exp_timer.value_b = d;
                REG_TIMER: begin
                    exp_timer.load_a     = d[0];
                    exp_timer.load_b     = d[1];
                    exp_timer.irq_en_a   = d[2];
                    exp_timer.irq_en_b   = d[3];
                    exp_timer.clr_flag_a = d[4];
                    exp_timer.clr_flag_b = d[5];
                    exp_timer.effect     = d[7] | d[6];
                    exp_timer.csm        = d[7] & ~d[6];
                end
                REG_PCM:     exp_pcm.sample = {~d[7], d[6:0], 1'b1};
                REG_DACTEST: exp_pcm.sample[0] = d[3];
                REG_PCM_EN:  exp_pcm.en = d[7];
                default: ;
            endcase
        end
        exp_pcm.wr = num == REG_PCM;
        exp_update.keyon = !part && num == REG_KON;
        exp_update.ch    = {part, num[1:0]};
        exp_update.op    = num[3:2];
        exp_update.data  = d;
        exp_update.ch_up = 3'b000;
        exp_update.op_up = 7'b0000000;
        if (num[1:0] != 2'b11) begin
            if (num inside {8'hA0, 8'hA1, 8'hA2}) exp_update.ch_up = 3'b001;
            if (num inside {8'hB0, 8'hB1, 8'hB2}) exp_update.ch_up = 3'b010;
            if (num inside {8'hB4, 8'hB5, 8'hB6}) exp_update.ch_up = 3'b100;
            if (hi >= 4'd3 && hi <= 4'd9) exp_update.op_up = 7'b1 << (hi - 4'd3);
        end
    endtask

    // Select and data write followed by two output checks
    task automatic host_write(input logic part, input logic [7:0] num, input logic [7:0] d);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b0};
        din   <= num;
        @(posedge clk);
        addr  <= {part, 1'b1};
        din   <= d;
        apply_model(part, num, d);
        due_cyc = cyc + 3; // Outputs 3 edges after the data drive
        checks++;
        @(posedge clk);
        write <= 1'b0;
        repeat (8) @(posedge clk);
        exp_timer.clr_flag_a = 1'b0; // Pulses settled by now
        exp_timer.clr_flag_b = 1'b0;
        exp_pcm.wr           = 1'b0;
        due_cyc = cyc + 1;
        checks++;
        @(posedge clk);
    endtask

    a_globals: assert property (
        @(posedge clk) disable iff (rst)
        (cyc == due_cyc) |->
            (timer == exp_timer && lfo == exp_lfo && test == exp_test && pcm == exp_pcm)
    ) else report_fail("global register outputs differ from the model");

    a_update: assert property (
        @(posedge clk) disable iff (rst)
        (cyc == due_cyc) |-> update == exp_update
    ) else report_fail("update strobes or fields differ from the model");

    // Spacing of clk_en in clocks with cen high after one settling interval
    task automatic measure_spacing(input int ratio);
        int n;
        do @(negedge clk); while (!clk_en);
        for (int k = 0; k < 2; k++) begin
            n = 0;
            do begin
                @(negedge clk);
                if (cen) n++;
            end while (!clk_en);
        end
        checks++;
        a_spacing: assert (n == ratio)
            else report_fail($sformatf("clk_en spacing %0d, expected %0d", n, ratio));
    endtask

    task automatic busy_check(input logic [7:0] d);
        int n;
        do @(negedge clk); while (busy);
        @(posedge clk);
        write <= 1'b1;
        addr  <= 2'b00;
        din   <= REG_LFO;
        @(posedge clk);
        addr  <= 2'b01;
        din   <= d;
        apply_model(1'b0, REG_LFO, d);
        due_cyc = cyc + 3;
        @(posedge clk);
        write <= 1'b0;
        @(negedge clk);
        a_busy_low: assert (!busy) else report_fail("busy rose too early");
        @(negedge clk);
        a_busy_high: assert (busy) else report_fail("busy did not rise after write");
        n = 0;
        while (n < BUSY_CYCLES) begin
            if (clk_en) n++;
            @(negedge clk);
            if (n < BUSY_CYCLES) begin
                a_busy_hold: assert (busy) else report_fail("busy fell too early");
            end else begin
                a_busy_fall: assert (!busy) else report_fail("busy stayed high too long");
            end
        end
        checks++;
    endtask

    initial begin
        logic [7:0] num;
        int         idx;
        rst = 1'b1;
        cen = 1'b1;
        din = 8'h00;
        write = 1'b0;
        addr = 2'b00;
        cyc = 0;
        due_cyc = -1;
        errors = 0;
        checks = 0;
        cen_toggle = 1'b0;
        lfsr = 32'h1cb9_1534;
        exp_timer = '0;
        exp_lfo = '0;
        exp_pcm = '0;
        exp_test = '0;
        exp_update = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        measure_spacing(6); // Reset setting
        host_write(1'b0, REG_CLK_N2, 8'(take_bits(8)));
        measure_spacing(2);
        host_write(1'b0, REG_CLK_N3, 8'(take_bits(8)));
        measure_spacing(3);
        cen_toggle = 1'b1;
        measure_spacing(3);
        cen_toggle = 1'b0;

        repeat (40) begin
            idx = int'(take_bits(2));
            case (idx)
                0: num = REG_CLKA1;
                1: num = REG_CLKA2;
                2: num = REG_CLKB;
                default: num = REG_TIMER;
            endcase
            host_write(1'b0, num, 8'(take_bits(8)));
        end

        repeat (30) begin
            idx = int'(take_bits(3)) % 5;
            case (idx)
                0: num = REG_LFO;
                1: num = REG_TEST;
                2: num = REG_PCM;
                3: num = REG_DACTEST;
                default: num = REG_PCM_EN;
            endcase
            host_write(1'b0, num, 8'(take_bits(8)));
        end

        // Operator and channel registers in both parts
        repeat (80) begin
            num = 8'h30 + 8'(take_bits(8) % 32'd136);
            host_write(take_bits(1) != 0, num, 8'(take_bits(8)));
        end

        host_write(1'b0, REG_KON, 8'(take_bits(8)));
        host_write(1'b1, REG_KON, 8'(take_bits(8)));

        repeat (3) busy_check(8'(take_bits(8)));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/fm_mmr.sv */
`timescale 1ns/1ps

module fm_mmr #(
    parameter int USE_PCM = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [7:0]              din,
    input  logic                    write,
    input  logic [1:0]              addr,
    output logic                    clk_en,
    output logic                    busy,
    output fm_mmr_pkg::fm_timer_t   timer,
    output fm_mmr_pkg::fm_lfo_t     lfo,
    output fm_mmr_pkg::fm_pcm_t     pcm,
    output fm_mmr_pkg::fm_test_t    test,
    output fm_mmr_pkg::fm_update_t  update
);

    import fm_mmr_pkg::*;

    fm_bus_word_t word;
    logic         word_valid;
    logic         word_start;
    fm_div_t      div_sel;

    fm_bus_capture u_bus_capture (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .write      (write),
        .addr       (addr),
        .word       (word),
        .word_valid (word_valid),
        .word_start (word_start)
    );

    fm_global_regs #(
        .USE_PCM (USE_PCM)
    ) u_global_regs (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .word       (word),
        .word_valid (word_valid),
        .timer      (timer),
        .lfo        (lfo),
        .pcm        (pcm),
        .test       (test),
        .div_sel    (div_sel)
    );

    fm_update_decode u_update_decode (
        .clk        (clk),
        .rst        (rst),
        .word       (word),
        .word_valid (word_valid),
        .update     (update)
    );

    fm_prescaler u_prescaler (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_busy_timer u_busy_timer (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .word_start (word_start),
        .busy       (busy)
    );

endmodule

/* verilog/fm_busy_timer.sv */
`timescale 1ns/1ps

module fm_busy_timer (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic word_start,
    output logic busy
);

    import fm_mmr_pkg::*;

    logic [4:0] cnt; // Enables seen since the last write

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 5'd0;
        end else if (word_start) begin
            busy <= 1'b1; // New write restarts the count
            cnt  <= 5'd0;
        end else if (clk_en && busy) begin
            cnt <= cnt + 5'd1;
            if (cnt == 5'(BUSY_CYCLES - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    a_idle_count: assert property (
        @(posedge clk) disable iff (rst)
        (!busy && !word_start) |=> $stable(cnt)
    ) else $error("busy counter advanced while idle");

endmodule

/* verilog/fm_prescaler.sv */
`timescale 1ns/1ps

module fm_prescaler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  fm_mmr_pkg::fm_div_t   div_sel,
    output logic                  clk_en
);

    logic [2:0] ratio;
    logic [2:0] cnt;

    always_comb begin
        case (div_sel)
            2'd0:    ratio = 3'd2;
            2'd1:    ratio = 3'd3;
            default: ratio = 3'd6;
        endcase
    end

    // Counts only clocks with cen high
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= 3'd0;
        end else if (cen) begin
            // >= catches a ratio that shrank mid-count
            if (cnt >= ratio - 3'd1) begin
                cnt <= 3'd0;
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    assign clk_en = cen && cnt == 3'd0;

    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (rst)
        (ratio > 3'd1 && clk_en) |=> !clk_en
    ) else $error("clk_en high on two consecutive cycles");

endmodule

/* verilog/fm_update_decode.sv */
`timescale 1ns/1ps

module fm_update_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  fm_mmr_pkg::fm_bus_word_t   word,
    input  logic                       word_valid,
    output fm_mmr_pkg::fm_update_t     update
);

    import fm_mmr_pkg::*;

    logic [2:0] ch_up_nxt;
    logic [6:0] op_up_nxt;

    always_comb begin
        ch_up_nxt = 3'b000;
        op_up_nxt = 7'b0000000;
        // Slot 3 of each group does not exist
        if (word.reg_num[1:0] != 2'b11) begin
            casez (word.reg_num)
                8'hA0, 8'hA1, 8'hA2: ch_up_nxt = 3'b001; // fnum low
                8'hB0, 8'hB1, 8'hB2: ch_up_nxt = 3'b010; // FB and algorithm
                8'hB4, 8'hB5, 8'hB6: ch_up_nxt = 3'b100; // pms
                8'h3?: op_up_nxt = 7'b0000001;
                8'h4?: op_up_nxt = 7'b0000010;
                8'h5?: op_up_nxt = 7'b0000100;
                8'h6?: op_up_nxt = 7'b0001000;
                8'h7?: op_up_nxt = 7'b0010000;
                8'h8?: op_up_nxt = 7'b0100000;
                8'h9?: op_up_nxt = 7'b1000000; // SSG-EG
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            update.keyon <= 1'b0;
            update.ch_up <= 3'b000;
            update.op_up <= 7'b0000000;
        end else if (word_valid) begin
            update.keyon <= !word.part && word.reg_num == REG_KON;
            update.ch_up <= ch_up_nxt;
            update.op_up <= op_up_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            update.ch   <= {word.part, word.reg_num[1:0]};
            update.op   <= word.reg_num[3:2]; // 0=S1, 1=S3, 2=S2, 3=S4
            update.data <= word.data;
        end
    end

    a_one_target: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({update.ch_up, update.op_up})
    ) else $error("more than one update strobe active");

endmodule

/* verilog/fm_global_regs.sv */
`timescale 1ns/1ps

module fm_global_regs #(
    parameter int USE_PCM = 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clk_en,
    input  fm_mmr_pkg::fm_bus_word_t   word,
    input  logic                       word_valid,
    output fm_mmr_pkg::fm_timer_t      timer,
    output fm_mmr_pkg::fm_lfo_t        lfo,
    output fm_mmr_pkg::fm_pcm_t        pcm,
    output fm_mmr_pkg::fm_test_t       test,
    output fm_mmr_pkg::fm_div_t        div_sel
);

    import fm_mmr_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer   <= '0;
            lfo     <= '0;
            test    <= '0;
            pcm     <= '0;
            div_sel <= 2'b11; // Divide by 6
        end else if (word_valid) begin
            // Globals only live in part 0
            if (!word.part) begin
                case (word.reg_num)
                    REG_TEST: begin
                        test.eg_stop <= word.data[5];
                        test.pg_stop <= word.data[3];
                        timer.fast   <= word.data[2];
                    end
                    REG_LFO:   {lfo.en, lfo.freq} <= word.data[3:0];
                    REG_CLKA1: timer.value_a[9:2] <= word.data;
                    REG_CLKA2: timer.value_a[1:0] <= word.data[1:0];
                    REG_CLKB:  timer.value_b      <= word.data;
                    REG_TIMER: begin
                        // Mode bits 7:6, 2'b10 is CSM
                        timer.effect <= |word.data[7:6];
                        timer.csm    <= word.data[7:6] == 2'b10;
                        {timer.clr_flag_b, timer.clr_flag_a,
                         timer.irq_en_b, timer.irq_en_a,
                         timer.load_b, timer.load_a} <= word.data[5:0];
                    end
                    REG_CLK_N6: div_sel[1] <= 1'b1;
                    REG_CLK_N3: div_sel[0] <= 1'b1;
                    REG_CLK_N2: div_sel    <= 2'b00;
                    default: ;
                endcase
            end

            // DAC registers, bank not decoded
            if (USE_PCM != 0) begin
                case (word.reg_num)
                    REG_PCM:     pcm.sample    <= {~word.data[7], word.data[6:0], 1'b1};
                    REG_DACTEST: pcm.sample[0] <= word.data[3];
                    REG_PCM_EN:  pcm.en        <= word.data[7];
                    default: ;
                endcase
                pcm.wr <= word.reg_num == REG_PCM;
            end
        end else if (clk_en) begin
            timer.clr_flag_a <= 1'b0; // One-shot bits
            timer.clr_flag_b <= 1'b0;
            pcm.wr           <= 1'b0;
        end
    end

    // CSM is a special case of the effect mode
    a_csm_effect: assert property (
        @(posedge clk) disable iff (rst)
        timer.csm |-> timer.effect
    ) else $error("csm set without effect mode");

endmodule

/* verilog/fm_bus_capture.sv */
`timescale 1ns/1ps

module fm_bus_capture (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 din,
    input  logic                       write,
    input  logic [1:0]                 addr,
    output fm_mmr_pkg::fm_bus_word_t   word,
    output logic                       word_valid,
    output logic                       word_start
);

    logic [7:0] sel_reg;
    logic       sel_part;
    logic       data_wr;
    logic       sel_wr;

    assign data_wr = write & addr[0];
    assign sel_wr  = write & ~addr[0];

    // Register select, addr[1] picks the bank
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg  <= 8'h00;
            sel_part <= 1'b0;
        end else if (sel_wr) begin
            sel_reg  <= din;
            sel_part <= addr[1];
        end
    end

    // Payload of the word carries no reset
    always_ff @(posedge clk) begin
        if (data_wr) begin
            word.part    <= sel_part;
            word.reg_num <= sel_reg;
            word.data    <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word_valid <= 1'b0;
            word_start <= 1'b0;
        end else begin
            word_valid <= data_wr;
            // word_valid doubles as the previous data write
            word_start <= data_wr & ~word_valid;
        end
    end

endmodule

/* verilog/fm_mmr_pkg.sv */
package fm_mmr_pkg;

    // Global register numbers, part 0
    localparam logic [7:0] REG_TEST    = 8'h21;
    localparam logic [7:0] REG_LFO     = 8'h22;
    localparam logic [7:0] REG_CLKA1   = 8'h24; // Timer A high bits
    localparam logic [7:0] REG_CLKA2   = 8'h25; // Timer A low bits
    localparam logic [7:0] REG_CLKB    = 8'h26;
    localparam logic [7:0] REG_TIMER   = 8'h27;
    localparam logic [7:0] REG_KON     = 8'h28;
    localparam logic [7:0] REG_PCM     = 8'h2A;
    localparam logic [7:0] REG_PCM_EN  = 8'h2B;
    localparam logic [7:0] REG_DACTEST = 8'h2C;
    localparam logic [7:0] REG_CLK_N6  = 8'h2D;
    localparam logic [7:0] REG_CLK_N3  = 8'h2E;
    localparam logic [7:0] REG_CLK_N2  = 8'h2F;

    localparam int TIMER_A_W   = 10;
    localparam int TIMER_B_W   = 8;
    localparam int PCM_W       = 9;
    localparam int BUSY_CYCLES = 32; // Enables per data write

    // One host data write with its target register
    typedef struct packed {
        logic       part;
        logic [7:0] reg_num;
        logic [7:0] data;
    } fm_bus_word_t;

    typedef struct packed {
        logic [TIMER_A_W-1:0] value_a;
        logic [TIMER_B_W-1:0] value_b;
        logic                 load_a;
        logic                 load_b;
        logic                 irq_en_a;
        logic                 irq_en_b;
        logic                 clr_flag_a; // Pulse
        logic                 clr_flag_b; // Pulse
        logic                 fast;
        logic                 csm;
        logic                 effect;
    } fm_timer_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } fm_lfo_t;

    typedef struct packed {
        logic [PCM_W-1:0] sample;
        logic             en;
        logic             wr;     // Pulse after a sample write
    } fm_pcm_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
    } fm_test_t;

    // Strobes towards the channel and operator register file
    typedef struct packed {
        logic       keyon;
        logic [2:0] ch_up; // fnum low, algorithm, pms
        logic [6:0] op_up; // dt1/mul, tl, ks/ar, amen/dr, sr, sl/rr, ssg-eg
        logic [2:0] ch;    // Part, then register bits 1:0
        logic [1:0] op;
        logic [7:0] data;
    } fm_update_t;

    // 0 is divide by 2, 1 by 3, 2 and 3 by 6
    typedef logic [1:0] fm_div_t;

endpackage
